/* testbench/divsqrt_cases.txt */
# Columns in hex: op rm operand_a operand_b result flags
# op 0 div 1 sqrt, rm 0 rne 1 rtz 2 rdn 3 rup, flags nv dz of uf nx from msb
0 0 40C00000 40400000 40000000 00
1 0 41800000 00000000 40800000 00
1 0 40100000 00000000 3FC00000 00
0 0 3F800000 40400000 3EAAAAAB 01
0 1 3F800000 40400000 3EAAAAAA 01
0 2 3F800000 40400000 3EAAAAAA 01
0 3 3F800000 40400000 3EAAAAAB 01
0 2 BF800000 40400000 BEAAAAAB 01
1 0 40000000 00000000 3FB504F3 01
1 1 40000000 00000000 3FB504F3 01
1 3 40000000 00000000 3FB504F4 01
0 0 00000001 00800000 34000000 00
0 0 00400000 3F000000 00800000 00
0 0 35800000 00200000 75800000 00
1 0 00000002 00000000 1A800000 00
1 0 00000001 00000000 1A3504F3 01
0 0 7F800001 3F800000 7FC00000 10
0 0 00000000 80000000 7FC00000 10
0 0 7F800000 FF800000 7FC00000 10
0 0 C0000000 00000000 FF800000 08
0 0 40A00000 7F800000 00000000 00
1 0 BF800000 00000000 7FC00000 10
1 0 80000000 00000000 80000000 00
0 0 7F7FFFFF 00800000 7F800000 05
0 1 7F7FFFFF 00800000 7F7FFFFF 05
0 2 FF7FFFFF 00800000 FF800000 05
0 3 FF7FFFFF 00800000 FF7FFFFF 05
0 3 00800000 7F7FFFFF 00000000 03
0 2 80800000 7F7FFFFF 80000000 03
0 0 40E00000 40000000 40600000 00
0 0 3F800000 00000000 7F800000 08

/* flist.f */
design/fp_format_pkg.sv
design/divsqrt_ctrl_pkg.sv
design/lead_one_detect.sv
design/divsqrt_preprocess.sv
design/divsqrt_iterate.sv
design/divsqrt_round_pack.sv
design/divsqrt_top.sv
testbench/divsqrt_checker.sv
testbench/divsqrt_tb.sv

/* testbench/divsqrt_tb.sv */
////////////////////////////////////////
// Testbench top for the divide/sqrt unit
// Clock, reset and random back-pressure
// Reads cases and drives the requests
// Drain wait and closing summary
////////////////////////////////////////

`timescale 1ns/1ps

module divsqrt_tb
   import divsqrt_ctrl_pkg::*;
();

   localparam int CLK_PERIOD    = 4;
   localparam int SAMPLE_DLY    = 1;
   localparam int READY_TIMEOUT = 200;
   localparam int DRAIN_TIMEOUT = 2000;

   logic               Clk_CI, Rst_RBI;
   logic               in_valid, in_ready, out_valid, out_ready;
   divsqrt_op_e        op;
   rm_e                rm;
   logic [31:0]        operand_a, operand_b, result;
   logic [C_FLAGS-1:0] flags;
   bit                 timed_out, file_error;

   divsqrt_top divsqrt_top_i
   (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .op        (op),
      .rm        (rm),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .result    (result),
      .flags     (flags)
   );

   divsqrt_checker divsqrt_checker_i
   (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .result    (result),
      .flags     (flags)
   );

   initial
   begin
      Clk_CI = 1'b0;
      forever #(CLK_PERIOD / 2) Clk_CI = ~Clk_CI;
   end

   // Result back-pressure, roughly one stall in four
   initial
   begin
      out_ready = 1'b1;
      void'($urandom(32'hab70));
      forever
      begin
         @(negedge Clk_CI);
         out_ready = (($urandom % 4) != 0);
      end
   end

   ////////////////////////////////////////
   // Request driver and drain
   ////////////////////////////////////////

   // Entered on a falling edge, returns on the falling edge after the transfer
   task automatic send_request(input int test_id, input logic [31:0] op_v,
                               input logic [31:0] rm_v, input logic [31:0] a_v,
                               input logic [31:0] b_v);
      int wait_cnt;
      bit accepted;
      in_valid  = 1'b1;
      op        = divsqrt_op_e'(op_v[0]);
      rm        = rm_e'(rm_v[2:0]);
      operand_a = a_v;
      operand_b = b_v;
      wait_cnt  = 0;
      accepted  = 1'b0;
      while (!accepted && !timed_out)
      begin
         // in_ready settles after out_ready changes
         #SAMPLE_DLY;
         if (in_ready)
         begin
            accepted = 1'b1;
         end
         else
         begin
            wait_cnt++;
            if (wait_cnt >= READY_TIMEOUT)
            begin
               $display("Timeout: in_ready stayed low for %0d cycles on test %0d",
                        wait_cnt, test_id);
               timed_out = 1'b1;
            end
         end
         @(negedge Clk_CI);
      end
      in_valid = 1'b0;
   endtask

   task automatic wait_for_drain();
      int wait_cnt;
      wait_cnt = 0;
      while (divsqrt_checker_i.pending != 0 && !timed_out)
      begin
         @(negedge Clk_CI);
         wait_cnt++;
         if (wait_cnt >= DRAIN_TIMEOUT)
         begin
            $display("Timeout: %0d results still outstanding after %0d cycles",
                     divsqrt_checker_i.pending, wait_cnt);
            timed_out = 1'b1;
         end
      end
   endtask

   initial
   begin
      int          fd, fields, test_cnt, fail_total;
      string       line;
      logic [31:0] op_v, rm_v, a_v, b_v, res_v, flg_v;
      Rst_RBI    = 1'b0;
      in_valid   = 1'b0;
      op         = OP_DIV;
      rm         = RM_RNE;
      operand_a  = '0;
      operand_b  = '0;
      timed_out  = 1'b0;
      file_error = 1'b0;
      test_cnt   = 0;

      // Two cycles of reset, released away from the rising edge
      repeat (2) @(posedge Clk_CI);
      @(negedge Clk_CI);
      Rst_RBI = 1'b1;
      @(negedge Clk_CI);

      fd = $fopen("testbench/divsqrt_cases.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open testbench/divsqrt_cases.txt for reading");
         file_error = 1'b1;
      end
      else
      begin
         while (!timed_out && $fgets(line, fd) > 0)
         begin
            // Skip blank and comment lines
            if (line.len() > 1 && line[0] != "#")
            begin
               fields = $sscanf(line, "%h %h %h %h %h %h",
                                op_v, rm_v, a_v, b_v, res_v, flg_v);
               if (fields == 6)
               begin
                  test_cnt++;
                  divsqrt_checker_i.push_expected(test_cnt, res_v, flg_v[C_FLAGS-1:0]);
                  send_request(test_cnt, op_v, rm_v, a_v, b_v);
               end
               else
               begin
                  $display("Cases file line has %0d fields instead of 6: %s", fields, line);
                  file_error = 1'b1;
               end
            end
         end
         $fclose(fd);
      end

      wait_for_drain();
      // A few idle cycles to catch stray results
      repeat (4) @(negedge Clk_CI);

      fail_total = divsqrt_checker_i.fail_cnt + int'(timed_out) + int'(file_error);
      $display("Tests %0d, passed %0d, failed %0d", test_cnt,
               divsqrt_checker_i.pass_cnt, fail_total);
      if (fail_total == 0 && test_cnt > 0 && divsqrt_checker_i.pass_cnt == test_cnt)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* testbench/divsqrt_checker.sv */
////////////////////////////////////////
// Result checker for the divide/sqrt unit
// Queue of expected results and flags
// Compares each result port transfer
// Per-test report lines and counters
////////////////////////////////////////

`timescale 1ns/1ps

module divsqrt_checker
   import divsqrt_ctrl_pkg::*;
(
   input  logic               Clk_CI,
   input  logic               Rst_RBI,
   input  logic               out_valid,
   input  logic               out_ready,
   input  logic [31:0]        result,
   input  logic [C_FLAGS-1:0] flags
);

   // Strobe point after the falling edge, well before the rising edge
   localparam int SAMPLE_DLY = 1;

   // Expected items in request order
   int                 test_q[$];
   logic [31:0]        result_q[$];
   logic [C_FLAGS-1:0] flags_q[$];

   int pass_cnt = 0;
   int fail_cnt = 0;
   int pending  = 0;

   // Called by the driver for every request it issues
   task automatic push_expected(input int test_id, input logic [31:0] exp_result,
                                input logic [C_FLAGS-1:0] exp_flags);
      test_q.push_back(test_id);
      result_q.push_back(exp_result);
      flags_q.push_back(exp_flags);
      pending = test_q.size();
   endtask

   task automatic compare_result();
      int                 test_id;
      logic [31:0]        exp_result;
      logic [C_FLAGS-1:0] exp_flags;
      bit                 match;
      if (test_q.size() == 0)
      begin
         $display("At %0t ns a result %h left the unit with no request outstanding",
                  $time, result);
         fail_cnt++;
      end
      else
      begin
         test_id    = test_q.pop_front();
         exp_result = result_q.pop_front();
         exp_flags  = flags_q.pop_front();
         match      = 1'b1;
         if (result !== exp_result)
         begin
            $display("CHECK FAILED at %0t ns: result is %h, expected %h",
                     $time, result, exp_result);
            match = 1'b0;
         end
         if (flags !== exp_flags)
         begin
            $display("CHECK FAILED at %0t ns: flags is %b, expected %b",
                     $time, flags, exp_flags);
            match = 1'b0;
         end
         if (match)
         begin
            pass_cnt++;
            $display("Test %0d passed: result %h flags %b", test_id, result, flags);
         end
         else
         begin
            fail_cnt++;
            $display("Test %0d did not match", test_id);
         end
      end
      pending = test_q.size();
   endtask

   // Transfer takes place on the next rising edge
   always @(negedge Clk_CI)
   begin
      #SAMPLE_DLY;
      if (Rst_RBI && out_valid && out_ready)
      begin
         compare_result();
      end
   end

endmodule

/* design/divsqrt_top.sv */
////////////////////////////////////////
// Divide and square-root unit top
// Preprocess, iterate, round and pack
// chained by valid/ready handshakes
////////////////////////////////////////

`timescale 1ns/1ps

module divsqrt_top
   import fp_format_pkg::*;
   import divsqrt_ctrl_pkg::*;
(
   input  logic                Clk_CI,
   input  logic                Rst_RBI,
   // Requests
   input  logic                in_valid,
   output logic                in_ready,
   input  divsqrt_op_e         op,
   input  rm_e                 rm,
   input  logic [C_OP-1:0]     operand_a,
   input  logic [C_OP-1:0]     operand_b,
   // Results
   output logic                out_valid,
   input  logic                out_ready,
   output logic [C_OP-1:0]     result,
   output logic [C_FLAGS-1:0]  flags
);

   // Preprocess to iterate
   logic                    pre_valid, pre_ready, pre_sign_z, pre_special;
   divsqrt_op_e             pre_op;
   rm_e                     pre_rm;
   logic signed [C_EXP+1:0] pre_exp_a, pre_exp_b;
   logic [C_MANT:0]         pre_mant_a, pre_mant_b;
   logic                    pre_zero_a, pre_zero_b, pre_inf_a, pre_inf_b;
   logic                    pre_nan_a, pre_nan_b;

   // Iterate to round and pack
   logic                    it_valid, it_ready, it_sign, it_special, it_sticky;
   divsqrt_op_e             it_op;
   rm_e                     it_rm;
   logic signed [C_EXP+1:0] it_exp;
   logic [C_ITER-1:0]       it_mant;
   logic                    it_zero_a, it_zero_b, it_inf_a, it_inf_b;
   logic                    it_nan_a, it_nan_b;

   // Port names match the wires above
   divsqrt_preprocess preprocess_i (.*);

   divsqrt_iterate iterate_i (.*);

   divsqrt_round_pack round_pack_i (.*);

endmodule

/* design/divsqrt_round_pack.sv */
////////////////////////////////////////
// Third stage of the divide/sqrt unit
// Exponent rebias and rounding
// Overflow and flush-to-zero underflow
// Special results and exception flags
////////////////////////////////////////

`timescale 1ns/1ps

module divsqrt_round_pack
   import fp_format_pkg::*;
   import divsqrt_ctrl_pkg::*;
(
   input  logic                    Clk_CI,
   input  logic                    Rst_RBI,
   // From iterator
   input  logic                    it_valid,
   output logic                    it_ready,
   input  divsqrt_op_e             it_op,
   input  rm_e                     it_rm,
   input  logic                    it_sign,
   input  logic                    it_special,
   input  logic                    it_zero_a,
   input  logic                    it_zero_b,
   input  logic                    it_inf_a,
   input  logic                    it_inf_b,
   input  logic                    it_nan_a,
   input  logic                    it_nan_b,
   input  logic signed [C_EXP+1:0] it_exp,
   input  logic [C_ITER-1:0]       it_mant,
   input  logic                    it_sticky,
   // Result side
   output logic                    out_valid,
   input  logic                    out_ready,
   output logic [C_OP-1:0]         result,
   output logic [C_FLAGS-1:0]      flags
);

   localparam int C_EXPW = C_EXP + 2;
   localparam logic signed [C_EXPW-1:0] C_EXP_LIM = {2'b00, C_EXP_INF};

   logic                     is_div, inexact, round_up, ovf_to_inf;
   logic                     res_nan, res_inf, div_zero, overflow, underflow;
   logic [C_MANT+1:0]        mant_rnd;
   logic signed [C_EXPW-1:0] exp_biased, exp_final;
   logic [C_OP-1:0]          result_d;
   logic [C_FLAGS-1:0]       flags_d;

   ////////////////////////////////////////
   // Rounding
   ////////////////////////////////////////

   // Guard at bit 1, round at bit 0
   assign inexact = it_mant[1] | it_mant[0] | it_sticky;

   always_comb
   begin
      case (it_rm)
         RM_RTZ:  round_up = 1'b0;
         RM_RDN:  round_up = it_sign & inexact;
         RM_RUP:  round_up = ~it_sign & inexact;
         // Ties go to the even significand
         default: round_up = it_mant[1] & (it_mant[0] | it_sticky | it_mant[2]);
      endcase
   end

   assign mant_rnd   = {1'b0, it_mant[C_ITER-1:2]} + (C_MANT+2)'(round_up);
   assign exp_biased = it_exp + C_EXPW'(C_BIAS);
   // Carry out of the significand bumps the exponent
   assign exp_final  = exp_biased + C_EXPW'(mant_rnd[C_MANT+1]);
   assign overflow   = (exp_final >= C_EXP_LIM);
   assign underflow  = (exp_final <= 0);

   // Overflow saturates toward zero in the directed modes
   assign ovf_to_inf = (it_rm == RM_RTZ) ? 1'b0 :
                       (it_rm == RM_RDN) ? it_sign :
                       (it_rm == RM_RUP) ? ~it_sign : 1'b1;

   ////////////////////////////////////////
   // Special operands
   ////////////////////////////////////////

   assign is_div   = (it_op == OP_DIV);
   assign res_nan  = it_nan_a
                   | (is_div & (it_nan_b | (it_zero_a & it_zero_b) | (it_inf_a & it_inf_b)))
                   | (~is_div & it_sign & ~it_zero_a);
   assign res_inf  = is_div ? (it_inf_a | it_zero_b) : it_inf_a;
   assign div_zero = is_div & it_zero_b & ~it_zero_a & ~it_inf_a;

   always_comb
   begin
      flags_d = '0;
      if (res_nan)
      begin
         result_d            = C_QNAN;
         flags_d[C_FLAG_NV]  = 1'b1;
      end
      else if (it_special)
      begin
         result_d            = {it_sign, res_inf ? C_EXP_INF : C_EXP_ZERO, C_MANT_ZERO};
         flags_d[C_FLAG_DZ]  = div_zero;
      end
      else if (overflow)
      begin
         result_d            = ovf_to_inf ? {it_sign, C_EXP_INF, C_MANT_ZERO} :
                               {it_sign, C_EXP_INF - C_EXP'(1), ~C_MANT_ZERO};
         flags_d[C_FLAG_OF]  = 1'b1;
         flags_d[C_FLAG_NX]  = 1'b1;
      end
      else if (underflow)
      begin
         // No subnormal results, flush to signed zero
         result_d            = {it_sign, C_EXP_ZERO, C_MANT_ZERO};
         flags_d[C_FLAG_UF]  = 1'b1;
         flags_d[C_FLAG_NX]  = 1'b1;
      end
      else
      begin
         result_d            = {it_sign, exp_final[C_EXP-1:0], mant_rnd[C_MANT-1:0]};
         flags_d[C_FLAG_NX]  = inexact;
      end
   end

   ////////////////////////////////////////
   // Output register
   ////////////////////////////////////////

   assign it_ready = ~out_valid | out_ready;

   always_ff @(posedge Clk_CI or negedge Rst_RBI)
   begin
      if (!Rst_RBI)
      begin
         out_valid <= 1'b0;
      end
      else if (it_ready)
      begin
         out_valid <= it_valid;
      end
   end

   always_ff @(posedge Clk_CI)
   begin
      if (it_valid && it_ready)
      begin
         result <= result_d;
         flags  <= flags_d;
      end
   end

endmodule

/* design/divsqrt_iterate.sv */
////////////////////////////////////////
// Second stage of the divide/sqrt unit
// Restoring division, one bit per cycle
// Restoring digit-by-digit square root
// Exponent difference and halving
// Bypass for special operands
////////////////////////////////////////

`timescale 1ns/1ps

module divsqrt_iterate
   import fp_format_pkg::*;
   import divsqrt_ctrl_pkg::*;
(
   input  logic                    Clk_CI,
   input  logic                    Rst_RBI,
   // From preprocess
   input  logic                    pre_valid,
   output logic                    pre_ready,
   input  divsqrt_op_e             pre_op,
   input  rm_e                     pre_rm,
   input  logic                    pre_sign_z,
   input  logic signed [C_EXP+1:0] pre_exp_a,
   input  logic signed [C_EXP+1:0] pre_exp_b,
   input  logic [C_MANT:0]         pre_mant_a,
   input  logic [C_MANT:0]         pre_mant_b,
   input  logic                    pre_special,
   input  logic                    pre_zero_a,
   input  logic                    pre_zero_b,
   input  logic                    pre_inf_a,
   input  logic                    pre_inf_b,
   input  logic                    pre_nan_a,
   input  logic                    pre_nan_b,
   // To round and pack
   output logic                    it_valid,
   input  logic                    it_ready,
   output divsqrt_op_e             it_op,
   output rm_e                     it_rm,
   output logic                    it_sign,
   output logic                    it_special,
   output logic                    it_zero_a,
   output logic                    it_zero_b,
   output logic                    it_inf_a,
   output logic                    it_inf_b,
   output logic                    it_nan_a,
   output logic                    it_nan_b,
   output logic signed [C_EXP+1:0] it_exp,
   output logic [C_ITER-1:0]       it_mant,
   output logic                    it_sticky
);

   // Remainder must hold four times the partial root plus one
   localparam int C_REM = C_ITER + 3;
   localparam int C_RAD = 2 * C_ITER;
   localparam int C_CNT = $clog2(C_ITER);

   logic                    busy, accept, mant_a_small, bit_ge;
   logic [C_CNT-1:0]        cnt;
   logic [C_REM-1:0]        rem_q, rem_shift, trial, rem_sub, rem_next;
   logic [C_ITER-1:0]       quo_q;
   logic [C_RAD-1:0]        rad_q;
   logic [C_MANT:0]         divisor_q;
   logic [C_MANT+1:0]       dividend, radicand;
   logic signed [C_EXP+1:0] exp_div, exp_sqrt;

   assign accept    = pre_valid & pre_ready;
   assign pre_ready = ~busy & (~it_valid | it_ready);

   ////////////////////////////////////////
   // Operand setup
   ////////////////////////////////////////

   // Keep the quotient in [1,2)
   assign mant_a_small = (pre_mant_a < pre_mant_b);
   assign dividend     = mant_a_small ? {pre_mant_a, 1'b0} : {1'b0, pre_mant_a};
   assign exp_div      = pre_exp_a - pre_exp_b - (C_EXP+2)'(mant_a_small);

   // Odd exponent doubles the radicand, floor halving fixes the rest
   assign radicand = pre_exp_a[0] ? {pre_mant_a, 1'b0} : {1'b0, pre_mant_a};
   assign exp_sqrt = pre_exp_a >>> 1;

   ////////////////////////////////////////
   // One recurrence step
   ////////////////////////////////////////

   always_comb
   begin
      if (it_op == OP_SQRT)
      begin
         // Bring down two radicand bits, try 4q+1
         rem_shift = {rem_q[C_REM-3:0], rad_q[C_RAD-1 -: 2]};
         trial     = {1'b0, quo_q, 2'b01};
      end
      else
      begin
         rem_shift = rem_q;
         trial     = C_REM'(divisor_q);
      end
      bit_ge   = (rem_shift >= trial);
      rem_sub  = bit_ge ? rem_shift - trial : rem_shift;
      rem_next = (it_op == OP_SQRT) ? rem_sub : rem_sub << 1;
   end

   ////////////////////////////////////////
   // Control
   ////////////////////////////////////////

   always_ff @(posedge Clk_CI or negedge Rst_RBI)
   begin
      if (!Rst_RBI)
      begin
         busy     <= 1'b0;
         cnt      <= '0;
         it_valid <= 1'b0;
      end
      else if (accept)
      begin
         // Specials go out on the next cycle
         busy     <= ~pre_special;
         it_valid <= pre_special;
         cnt      <= C_CNT'(C_ITER - 1);
      end
      else if (busy)
      begin
         cnt <= cnt - 1'b1;
         if (cnt == '0)
         begin
            busy     <= 1'b0;
            it_valid <= 1'b1;
         end
      end
      else if (it_ready)
      begin
         it_valid <= 1'b0;
      end
   end

   // Datapath and item fields
   always_ff @(posedge Clk_CI)
   begin
      if (accept)
      begin
         it_op      <= pre_op;
         it_rm      <= pre_rm;
         it_sign    <= pre_sign_z;
         it_special <= pre_special;
         it_zero_a  <= pre_zero_a;
         it_zero_b  <= pre_zero_b;
         it_inf_a   <= pre_inf_a;
         it_inf_b   <= pre_inf_b;
         it_nan_a   <= pre_nan_a;
         it_nan_b   <= pre_nan_b;
         it_exp     <= (pre_op == OP_SQRT) ? exp_sqrt : exp_div;
         rem_q      <= (pre_op == OP_SQRT) ? '0 : C_REM'(dividend);
         rad_q      <= {radicand, {(C_RAD - C_MANT - 2){1'b0}}};
         divisor_q  <= pre_mant_b;
         quo_q      <= '0;
      end
      else if (busy)
      begin
         rem_q <= rem_next;
         rad_q <= rad_q << 2;
         quo_q <= {quo_q[C_ITER-2:0], bit_ge};
      end
   end

   assign it_mant   = quo_q;
   // Any remainder left means bits beyond round
   assign it_sticky = |rem_q;

endmodule

/* design/divsqrt_preprocess.sv */
////////////////////////////////////////
// First stage of the divide/sqrt unit
// Operand field split and classification
// Subnormal normalization via LOD
// Result sign and registered hand-off
////////////////////////////////////////

`timescale 1ns/1ps

module divsqrt_preprocess
   import fp_format_pkg::*;
   import divsqrt_ctrl_pkg::*;
(
   input  logic                    Clk_CI,
   input  logic                    Rst_RBI,
   // Request side
   input  logic                    in_valid,
   output logic                    in_ready,
   input  divsqrt_op_e             op,
   input  rm_e                     rm,
   input  logic [C_OP-1:0]         operand_a,
   input  logic [C_OP-1:0]         operand_b,
   // To iterator
   output logic                    pre_valid,
   input  logic                    pre_ready,
   output divsqrt_op_e             pre_op,
   output rm_e                     pre_rm,
   output logic                    pre_sign_z,
   output logic signed [C_EXP+1:0] pre_exp_a,
   output logic signed [C_EXP+1:0] pre_exp_b,
   output logic [C_MANT:0]         pre_mant_a,
   output logic [C_MANT:0]         pre_mant_b,
   output logic                    pre_special,
   output logic                    pre_zero_a,
   output logic                    pre_zero_b,
   output logic                    pre_inf_a,
   output logic                    pre_inf_b,
   output logic                    pre_nan_a,
   output logic                    pre_nan_b
);

   logic [C_EXP-1:0] exp_a, exp_b, exp_a_adj, exp_b_adj;
   logic [C_MANT:0]  mant_a, mant_b;
   logic [4:0]       lead_a, lead_b;
   logic             no_ones_a, no_ones_b;
   logic             is_sqrt, accept;
   logic             zero_a, zero_b, inf_a, inf_b, nan_a, nan_b;

   ////////////////////////////////////////
   // Field split and classes
   ////////////////////////////////////////

   assign exp_a  = operand_a[C_OP-2:C_MANT];
   assign exp_b  = operand_b[C_OP-2:C_MANT];
   // Hidden bit only for a non-zero exponent
   assign mant_a = {|exp_a, operand_a[C_MANT-1:0]};
   assign mant_b = {|exp_b, operand_b[C_MANT-1:0]};

   // Subnormals share the exponent of the smallest normal
   assign exp_a_adj = (exp_a == C_EXP_ZERO) ? C_EXP'(1) : exp_a;
   assign exp_b_adj = (exp_b == C_EXP_ZERO) ? C_EXP'(1) : exp_b;

   assign is_sqrt = (op == OP_SQRT);
   assign accept  = in_valid & in_ready;

   // Operand b is a don't-care for sqrt
   assign zero_a = no_ones_a;
   assign zero_b = no_ones_b & ~is_sqrt;
   assign inf_a  = (exp_a == C_EXP_INF) & (operand_a[C_MANT-1:0] == C_MANT_ZERO);
   assign inf_b  = (exp_b == C_EXP_INF) & (operand_b[C_MANT-1:0] == C_MANT_ZERO) & ~is_sqrt;
   assign nan_a  = (exp_a == C_EXP_INF) & (operand_a[C_MANT-1:0] != C_MANT_ZERO);
   assign nan_b  = (exp_b == C_EXP_INF) & (operand_b[C_MANT-1:0] != C_MANT_ZERO) & ~is_sqrt;

   lead_one_detect #(.VEC_LEN(C_MANT+1)) lod_a_i
   (
      .vec      (mant_a),
      .lead_pos (lead_a),
      .no_ones  (no_ones_a)
   );

   lead_one_detect #(.VEC_LEN(C_MANT+1)) lod_b_i
   (
      .vec      (mant_b),
      .lead_pos (lead_b),
      .no_ones  (no_ones_b)
   );

   ////////////////////////////////////////
   // Stage register
   ////////////////////////////////////////

   // Free when empty or when the held item moves on
   assign in_ready = ~pre_valid | pre_ready;

   always_ff @(posedge Clk_CI or negedge Rst_RBI)
   begin
      if (!Rst_RBI)
      begin
         pre_valid <= 1'b0;
      end
      else if (in_ready)
      begin
         pre_valid <= in_valid;
      end
   end

   always_ff @(posedge Clk_CI)
   begin
      if (accept)
      begin
         pre_op      <= op;
         pre_rm      <= rm;
         pre_sign_z  <= is_sqrt ? operand_a[C_OP-1] : operand_a[C_OP-1] ^ operand_b[C_OP-1];
         // Unbias, then correct for the normalizing shift
         pre_exp_a   <= (C_EXP+2)'(exp_a_adj) - (C_EXP+2)'(C_BIAS) - (C_EXP+2)'(lead_a);
         pre_exp_b   <= (C_EXP+2)'(exp_b_adj) - (C_EXP+2)'(C_BIAS) - (C_EXP+2)'(lead_b);
         pre_mant_a  <= mant_a << lead_a;
         pre_mant_b  <= mant_b << lead_b;
         pre_special <= zero_a | zero_b | inf_a | inf_b | nan_a | nan_b;
         pre_zero_a  <= zero_a;
         pre_zero_b  <= zero_b;
         pre_inf_a   <= inf_a;
         pre_inf_b   <= inf_b;
         pre_nan_a   <= nan_a;
         pre_nan_b   <= nan_b;
      end
   end

endmodule

/* design/lead_one_detect.sv */
////////////////////////////////////////
// Leading-one detector
// Counts zeros above the first one
// Flags an all-zero vector
////////////////////////////////////////

`timescale 1ns/1ps

module lead_one_detect
#(
   parameter int unsigned VEC_LEN = 24
)
(
   input  logic [VEC_LEN-1:0] vec,
   output logic [4:0]         lead_pos,
   output logic               no_ones
);

   // Priority scan, topmost one wins
   always_comb
   begin
      lead_pos = '0;
      no_ones  = 1'b1;
      for (int i = VEC_LEN - 1; i >= 0; i--)
      begin
         if (vec[i] && no_ones)
         begin
            lead_pos = 5'(VEC_LEN - 1 - i);
            no_ones  = 1'b0;
         end
      end
   end

endmodule

/* design/divsqrt_ctrl_pkg.sv */
////////////////////////////////////////
// Divide and square-root control codes
// Operation select encoding
// Rounding-mode encoding
// Exception flag positions and width
////////////////////////////////////////

package divsqrt_ctrl_pkg;

   // Operation select
   typedef enum logic
   {
      OP_DIV  = 1'b0,
      OP_SQRT = 1'b1
   } divsqrt_op_e;

   // Rounding modes, unused codes round to nearest even
   typedef enum logic [2:0]
   {
      RM_RNE = 3'b000,
      RM_RTZ = 3'b001,
      RM_RDN = 3'b010,
      RM_RUP = 3'b011
   } rm_e;

   // Flag word layout
   localparam int C_FLAGS   = 5;
   localparam int C_FLAG_NV = 4;
   localparam int C_FLAG_DZ = 3;
   localparam int C_FLAG_OF = 2;
   localparam int C_FLAG_UF = 1;
   localparam int C_FLAG_NX = 0;

endpackage

/* design/fp_format_pkg.sv */
////////////////////////////////////////
// Binary32 format definitions
// Field widths and exponent bias
// Special exponent and mantissa codes
// Canonical quiet NaN word
// Length of the mantissa recurrence
////////////////////////////////////////

package fp_format_pkg;

   // Operand and field widths
   localparam int C_OP   = 32;
   localparam int C_EXP  = 8;
   localparam int C_MANT = 23;

   // Exponent bias
   localparam int C_BIAS = 127;

   ////////////////////////////////////////
   // Special field codes
   ////////////////////////////////////////

   // Zero and subnormal exponent
   localparam logic [C_EXP-1:0]  C_EXP_ZERO  = '0;
   // Infinity and NaN exponent
   localparam logic [C_EXP-1:0]  C_EXP_INF   = '1;
   localparam logic [C_MANT-1:0] C_MANT_ZERO = '0;

   // Every NaN result uses this word
   localparam logic [C_OP-1:0]   C_QNAN      = 32'h7fc0_0000;

   // Hidden bit, fraction, guard and round
   localparam int C_ITER = C_MANT + 3;

endpackage
